// File: bench/noc_assertions.sv
module noc_assertions #(
    parameter int NUM_NODES = 4
) (
    input logic                           clk,
    input logic                           reset,
    input logic                           done_i,
    input logic [31:0]                    cycle_count_i,
    input logic [NUM_NODES-1:0]           eject_valid_i,
    input noc_pkg::flit_t [NUM_NODES-1:0] eject_flit_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // a node only ejects its own traffic
    for (genvar k = 0; k < NUM_NODES; k++)
    begin : g_eject
        eject_at_dst: assert property (@(posedge clk) disable iff (reset)
            eject_valid_i[k] |-> (int'(eject_flit_i[k].dst) == k))
            else $error("node %0d ejected a flit for node %0d", k, eject_flit_i[k].dst);
    end

    quiet_when_done: assert property (@(posedge clk) disable iff (reset)
        done_i |-> (eject_valid_i == '0))
        else $error("eject valid high after the end of run");

    // first done cycle still sees the last count step
    count_frozen: assert property (@(posedge clk) disable iff (reset)
        (done_i && $past(done_i)) |-> $stable(cycle_count_i))
        else $error("cycle count moved after the end of run");

endmodule

bind noc_top noc_assertions #(
    .NUM_NODES (NUM_NODES)
) i_assertions (
    .clk           (clk),
    .reset         (reset),
    .done_i        (done_o),
    .cycle_count_i (cycle_count_o),
    .eject_valid_i (eject_valid_o),
    .eject_flit_i  (eject_flit_o)
);

// File: bench/noc_tb.sv
module noc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_NODES   = 4;
    localparam int QUEUE_DEPTH = 8;
    localparam int NUM_TESTS   = 5;
    // flits over all tests: single packets, self packet, random, overflow
    localparam int TOTAL_FLITS = 120 + 5 + NUM_NODES * 6 * 15 + 9 * 15;
    localparam int RUN_LIMIT   = TOTAL_FLITS * NUM_NODES + 200;  // cycles per test

    logic                           clk;
    logic                           reset;
    logic                           fill_i;
    logic [noc_pkg::NODE_W-1:0]     fill_node_i;
    noc_pkg::packet_t               fill_packet_i;
    logic                           start_i;
    logic                           done_o;
    logic [31:0]                    cycle_count_o;
    logic [NUM_NODES-1:0]           eject_valid_o;
    noc_pkg::flit_t [NUM_NODES-1:0] eject_flit_o;

    noc_pkg::flit_t exp_q [NUM_NODES*NUM_NODES][$];  // expected flits per (src, dst) pair
    int             fill_count [NUM_NODES];          // accepted fills per source
    int             min_cycles;                      // longest hops plus length
    bit             running;
    int             errors;
    int             total_errors;
    int             failed_tests;
    logic [31:0]    rng = 32'hb7930675;

    noc_top i_dut (
        .clk           (clk),
        .reset         (reset),
        .fill_i        (fill_i),
        .fill_node_i   (fill_node_i),
        .fill_packet_i (fill_packet_i),
        .start_i       (start_i),
        .done_o        (done_o),
        .cycle_count_o (cycle_count_o),
        .eject_valid_o (eject_valid_o),
        .eject_flit_o  (eject_flit_o)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~clk;
    end

    initial
    begin
        repeat (NUM_TESTS * RUN_LIMIT) @(posedge clk);
        $display("watchdog expired, the simulation did not finish in time");
        $display("tests failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Fail t=%0t %s expected %0h actual %0h", $time, name, exp, act);
        errors++;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset   = 1'b1;
        fill_i  = 1'b0;
        start_i = 1'b0;
        repeat (2) @(negedge clk);
        reset      = 1'b0;
        running    = 1'b0;
        min_cycles = 0;
        for (int i = 0; i < NUM_NODES; i++)
            fill_count[i] = 0;
        for (int p = 0; p < NUM_NODES * NUM_NODES; p++)
            exp_q[p].delete();
    endtask

    // one fill strobe; the model queues flits only for fills the DUT should keep
    task automatic fill_packet(input int src, input int dst, input int len);
        noc_pkg::flit_t f;
        int             hops;
        int             seq;
        fill_i            = 1'b1;
        fill_node_i       = src[noc_pkg::NODE_W-1:0];
        fill_packet_i.dst = dst[noc_pkg::NODE_W-1:0];
        fill_packet_i.len = len[noc_pkg::LEN_W-1:0];
        if (!running && fill_count[src] < QUEUE_DEPTH)
        begin
            seq  = fill_count[src];
            hops = (dst == src) ? NUM_NODES : (dst - src + NUM_NODES) % NUM_NODES;
            if (hops + len > min_cycles)
                min_cycles = hops + len;
            for (int i = 0; i < len; i++)
            begin
                f.head = (i == 0);
                f.tail = (i == len - 1);
                f.src  = src[noc_pkg::NODE_W-1:0];
                f.dst  = dst[noc_pkg::NODE_W-1:0];
                f.seq  = seq[noc_pkg::SEQ_W-1:0];
                f.idx  = i[noc_pkg::LEN_W-1:0];
                exp_q[src * NUM_NODES + dst].push_back(f);
            end
            fill_count[src]++;
        end
        @(negedge clk);
        fill_i = 1'b0;
    endtask

    task automatic collect_ejects();
        noc_pkg::flit_t f;
        int             pair;
        for (int k = 0; k < NUM_NODES; k++)
        begin
            if (eject_valid_o[k] === 1'b1)
            begin
                f    = eject_flit_o[k];
                pair = int'(f.src) * NUM_NODES + int'(f.dst);
                if (int'(f.dst) != k)
                    report_mismatch("eject_flit_o.dst", k, 32'(f.dst));
                else if (int'(f.src) >= NUM_NODES || exp_q[pair].size() == 0)
                begin
                    $display("Fail t=%0t unexpected flit %0h at node %0d", $time, f, k);
                    errors++;
                end
                else
                begin
                    if (f !== exp_q[pair][0])  // in seq then idx order per pair
                        report_mismatch("eject_flit_o", 32'(exp_q[pair][0]), 32'(f));
                    void'(exp_q[pair].pop_front());
                end
            end
        end
    endtask

    task automatic run_traffic(input bit late_fill);
        int          cycles;
        logic [31:0] final_count;
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        running = 1'b1;
        if (late_fill)
            fill_packet(0, 1, 2);  // first run cycle, nothing can eject yet
        cycles = 0;
        while (cycles < RUN_LIMIT)
        begin
            collect_ejects();
            if (done_o === 1'b1)
                break;
            @(negedge clk);
            cycles++;
        end
        if (done_o !== 1'b1)
        begin
            $display("Fail t=%0t done_o did not rise within %0d cycles", $time, RUN_LIMIT);
            errors++;
        end
        for (int p = 0; p < NUM_NODES * NUM_NODES; p++)
        begin
            if (exp_q[p].size() != 0)
            begin
                $display("Fail t=%0t %0d flits from node %0d to node %0d never arrived",
                         $time, exp_q[p].size(), p / NUM_NODES, p % NUM_NODES);
                errors++;
            end
        end
        if (cycle_count_o < min_cycles)
        begin
            $display("Fail t=%0t cycle_count_o %0d is below the minimum %0d",
                     $time, cycle_count_o, min_cycles);
            errors++;
        end
        final_count = cycle_count_o;
        repeat (5)
        begin
            @(negedge clk);
            collect_ejects();  // nothing may show up after done
        end
        if (cycle_count_o !== final_count)
            report_mismatch("cycle_count_o", final_count, cycle_count_o);
        if (done_o !== 1'b1)
            report_mismatch("done_o", 1, 32'(done_o));
    endtask

    task automatic test_reset();
        apply_reset();
        if (eject_valid_o !== '0)
            report_mismatch("eject_valid_o", 0, 32'(eject_valid_o));
        if (cycle_count_o !== 32'd0)
            report_mismatch("cycle_count_o", 0, cycle_count_o);
        repeat (20)
        begin
            if (done_o !== 1'b0)  // no start, so no end of run
                report_mismatch("done_o", 0, 32'(done_o));
            @(negedge clk);
        end
    endtask

    task automatic test_single_packets();
        for (int len = 1; len <= 15; len++)
        begin
            apply_reset();
            fill_packet(0, 2, len);
            run_traffic(1'b0);
        end
    endtask

    task automatic test_self_packet();
        apply_reset();
        fill_packet(1, 1, 5);  // full lap of the ring
        run_traffic(1'b0);
    endtask

    task automatic test_random_traffic();
        int dst;
        int len;
        apply_reset();
        for (int n = 0; n < NUM_NODES; n++)
        begin
            for (int p = 0; p < 6; p++)
            begin
                rng = xorshift(rng);
                dst = rng % NUM_NODES;
                rng = xorshift(rng);
                len = rng % 15 + 1;
                fill_packet(n, dst, len);
            end
        end
        run_traffic(1'b0);
    endtask

    task automatic test_overflow();
        apply_reset();
        for (int i = 0; i < 9; i++)
            fill_packet(3, i % NUM_NODES, i + 1);  // ninth finds the queue full
        run_traffic(1'b1);
    endtask

    task automatic finish_test(input string name);
        if (errors != 0)
            failed_tests++;
        $display("test %s finished with %0d errors", name, errors);
        total_errors += errors;
        errors = 0;
    endtask

    initial
    begin
        reset         = 1'b1;
        fill_i        = 1'b0;
        fill_node_i   = '0;
        fill_packet_i = '0;
        start_i       = 1'b0;
        errors        = 0;
        total_errors  = 0;
        failed_tests  = 0;
        test_reset();
        finish_test("reset");
        test_single_packets();
        finish_test("single_packets");
        test_self_packet();
        finish_test("self_packet");
        test_random_traffic();
        finish_test("random_traffic");
        test_overflow();
        finish_test("overflow");
        $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, failed_tests,
                 total_errors);
        if (failed_tests == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the ring NoC testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
    --top-module noc_tb -f src.f -o Vnoc_tb

./obj_dir/Vnoc_tb | tee sim.log

if grep -qx "all tests passed" sim.log
then
    echo "simulation PASS"
else
    echo "simulation FAIL"
    exit 1
fi

// File: src.f
verilog/noc_pkg.sv
verilog/noc_fifo.sv
verilog/noc_sequencer.sv
verilog/traffic_source.sv
verilog/ring_router.sv
verilog/noc_top.sv
bench/noc_assertions.sv
bench/noc_tb.sv

// File: verilog/noc_fifo.sv
module noc_fifo #(
    parameter int  DEPTH     = 8,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output payload_t pop_data_o,
    output logic     empty_o,
    output logic     full_o
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // pointer step with wrap, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign empty_o    = (count == '0);
    assign full_o     = (count == CNT_W'(DEPTH));
    assign do_push    = push_i && !full_o;  // push on full is dropped
    assign do_pop     = pop_i && !empty_o;
    assign pop_data_o = empty_o ? payload_t'('0) : mem[rd_ptr];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data_i;
    end

endmodule

// File: verilog/noc_pkg.sv
package noc_pkg;

    // field widths shared by the RTL and the bench
    localparam int NODE_W = 4;  // node id, up to 16 nodes
    localparam int LEN_W  = 4;  // packet length in flits
    localparam int SEQ_W  = 8;  // per-source packet number

    // queued packet descriptor, 8 bits
    typedef struct packed {
        logic [NODE_W-1:0] dst;
        logic [LEN_W-1:0]  len;  // 1 to 15 flits
    } packet_t;

    // one flit on the ring, 22 bits
    // head only on idx 0, tail only on idx len-1
    typedef struct packed {
        logic              head;
        logic              tail;
        logic [NODE_W-1:0] src;
        logic [NODE_W-1:0] dst;
        logic [SEQ_W-1:0]  seq;
        logic [LEN_W-1:0]  idx;  // position in packet, from 0
    } flit_t;

endpackage

// File: verilog/noc_sequencer.sv
module noc_sequencer #(
    parameter int NUM_NODES = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start_i,
    input  logic [2*NUM_NODES-1:0] all_idle_i,  // router and source idle bits
    output logic                   run_o,
    output logic                   done_o,
    output logic [31:0]            cycle_count_o
);
    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_DONE
    } state_t;

    state_t state;
    state_t next_state;
    logic   nodes_idle;

    // nothing queued and nothing in flight anywhere
    assign nodes_idle = &all_idle_i;

    always_comb
    begin
        next_state = state;
        case (state)
            S_IDLE:
            begin
                if (start_i)
                    next_state = S_RUN;
            end
            S_RUN:
            begin
                if (nodes_idle)
                    next_state = S_DONE;
            end
            S_DONE:
                next_state = S_DONE;  // held until reset
            default:
                next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= S_IDLE;
        else
            state <= next_state;
    end

    // run cycle counter, frozen once done
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            cycle_count_o <= '0;
        else if (state == S_RUN)
            cycle_count_o <= cycle_count_o + 32'd1;
    end

    assign run_o  = (state == S_RUN);
    assign done_o = (state == S_DONE);

endmodule

// File: verilog/noc_top.sv
module noc_top #(
    parameter int NUM_NODES   = 4,
    parameter int QUEUE_DEPTH = 8,
    parameter int BUF_DEPTH   = 16  // must exceed the longest packet
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           fill_i,
    input  logic [noc_pkg::NODE_W-1:0]     fill_node_i,
    input  noc_pkg::packet_t               fill_packet_i,
    input  logic                           start_i,
    output logic                           done_o,
    output logic [31:0]                    cycle_count_o,
    output logic [NUM_NODES-1:0]           eject_valid_o,
    output noc_pkg::flit_t [NUM_NODES-1:0] eject_flit_o
);
    logic                           run;
    logic [NUM_NODES-1:0]           src_idle;
    logic [NUM_NODES-1:0]           rtr_idle;
    logic [NUM_NODES-1:0]           inj_valid;
    logic [NUM_NODES-1:0]           inj_take;
    noc_pkg::flit_t [NUM_NODES-1:0] inj_flit;
    logic [NUM_NODES-1:0]           link_valid;  // slot k driven by router k
    logic [NUM_NODES-1:0]           link_full;   // slot k driven by router k
    noc_pkg::flit_t [NUM_NODES-1:0] link_flit;

    noc_sequencer #(
        .NUM_NODES (NUM_NODES)
    ) i_sequencer (
        .clk           (clk),
        .reset         (reset),
        .start_i       (start_i),
        .all_idle_i    ({rtr_idle, src_idle}),
        .run_o         (run),
        .done_o        (done_o),
        .cycle_count_o (cycle_count_o)
    );

    for (genvar k = 0; k < NUM_NODES; k++)
    begin : g_node
        localparam int PREV = (k + NUM_NODES - 1) % NUM_NODES;
        localparam int NEXT = (k + 1) % NUM_NODES;

        // source stage
        traffic_source #(
            .NODE_ID     (k),
            .QUEUE_DEPTH (QUEUE_DEPTH)
        ) i_source (
            .clk           (clk),
            .reset         (reset),
            .fill_i        (fill_i),
            .fill_node_i   (fill_node_i),
            .fill_packet_i (fill_packet_i),
            .run_i         (run),
            .inj_take_i    (inj_take[k]),
            .inj_valid_o   (inj_valid[k]),
            .inj_flit_o    (inj_flit[k]),
            .idle_o        (src_idle[k])
        );

        // router stage, fed by the previous node on the ring
        ring_router #(
            .NODE_ID   (k),
            .BUF_DEPTH (BUF_DEPTH)
        ) i_router (
            .clk           (clk),
            .reset         (reset),
            .link_valid_i  (link_valid[PREV]),
            .link_flit_i   (link_flit[PREV]),
            .link_full_i   (link_full[NEXT]),
            .inj_valid_i   (inj_valid[k]),
            .inj_flit_i    (inj_flit[k]),
            .link_full_o   (link_full[k]),
            .link_valid_o  (link_valid[k]),
            .link_flit_o   (link_flit[k]),
            .inj_take_o    (inj_take[k]),
            .eject_valid_o (eject_valid_o[k]),
            .eject_flit_o  (eject_flit_o[k]),
            .idle_o        (rtr_idle[k])
        );
    end

endmodule

// File: verilog/ring_router.sv
module ring_router #(
    parameter int NODE_ID   = 0,
    parameter int BUF_DEPTH = 16
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           link_valid_i,  // from upstream router
    input  noc_pkg::flit_t link_flit_i,
    input  logic           link_full_i,   // downstream buffer full
    input  logic           inj_valid_i,
    input  noc_pkg::flit_t inj_flit_i,
    output logic           link_full_o,
    output logic           link_valid_o,
    output noc_pkg::flit_t link_flit_o,
    output logic           inj_take_o,
    output logic           eject_valid_o,
    output noc_pkg::flit_t eject_flit_o,
    output logic           idle_o
);
    localparam logic [noc_pkg::NODE_W-1:0] MY_ID = NODE_ID[noc_pkg::NODE_W-1:0];

    // which stream holds the outgoing link between head and tail
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_RING,
        OWN_INJ
    } owner_t;

    owner_t         owner;
    noc_pkg::flit_t buf_head;
    logic           buf_push;
    logic           buf_pop;
    logic           buf_empty;
    logic           buf_full;
    logic           head_local;
    logic           eject;
    logic           forward;
    logic           inject;
    logic           reg_free;

    assign buf_push    = link_valid_i && !buf_full;
    assign link_full_o = buf_full;

    noc_fifo #(
        .DEPTH     (BUF_DEPTH),
        .payload_t (noc_pkg::flit_t)
    ) i_ring_buf (
        .clk         (clk),
        .reset       (reset),
        .push_i      (buf_push),
        .push_data_i (link_flit_i),
        .pop_i       (buf_pop),
        .pop_data_o  (buf_head),
        .empty_o     (buf_empty),
        .full_o      (buf_full)
    );

    assign head_local = (buf_head.dst == MY_ID);
    assign eject      = !buf_empty && head_local;  // no back-pressure on eject

    // link register empty, or its flit leaves this edge
    assign reg_free = !link_valid_o || !link_full_i;

    // ring traffic first, injection only into an empty buffer
    assign forward = !buf_empty && !head_local && reg_free && (owner != OWN_INJ);
    assign inject  = inj_valid_i && reg_free &&
                     ((owner == OWN_INJ) || ((owner == OWN_NONE) && buf_empty));

    assign inj_take_o = inject;
    assign buf_pop    = eject || forward;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            owner <= OWN_NONE;
        else if (forward)
            owner <= buf_head.tail ? OWN_NONE : OWN_RING;
        else if (inject)
            owner <= inj_flit_i.tail ? OWN_NONE : OWN_INJ;
    end

    // outgoing link register
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            link_valid_o <= 1'b0;
        else if (forward || inject)
            link_valid_o <= 1'b1;
        else if (!link_full_i)
            link_valid_o <= 1'b0;  // taken downstream
    end

    always_ff @(posedge clk)
    begin
        if (forward)
            link_flit_o <= buf_head;
        else if (inject)
            link_flit_o <= inj_flit_i;
    end

    // eject register, one pulse per flit
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            eject_valid_o <= 1'b0;
        else
            eject_valid_o <= eject;
    end

    always_ff @(posedge clk)
    begin
        if (eject)
            eject_flit_o <= buf_head;
    end

    assign idle_o = buf_empty && !link_valid_o;

endmodule

// File: verilog/traffic_source.sv
module traffic_source #(
    parameter int NODE_ID     = 0,
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       fill_i,
    input  logic [noc_pkg::NODE_W-1:0] fill_node_i,
    input  noc_pkg::packet_t           fill_packet_i,
    input  logic                       run_i,
    input  logic                       inj_take_i,
    output logic                       inj_valid_o,
    output noc_pkg::flit_t             inj_flit_o,
    output logic                       idle_o
);
    localparam logic [noc_pkg::NODE_W-1:0] MY_ID = NODE_ID[noc_pkg::NODE_W-1:0];

    noc_pkg::packet_t          cur_pkt;    // queue head, packet being sent
    logic                      q_push;
    logic                      q_pop;
    logic                      q_empty;
    logic                      q_full;
    logic [noc_pkg::LEN_W-1:0] idx;        // next flit of cur_pkt
    logic [noc_pkg::SEQ_W-1:0] seq;
    logic                      last_flit;

    // fills only before the run, and only for this node
    assign q_push = fill_i && (fill_node_i == MY_ID) && !run_i && !q_full;

    noc_fifo #(
        .DEPTH     (QUEUE_DEPTH),
        .payload_t (noc_pkg::packet_t)
    ) i_queue (
        .clk         (clk),
        .reset       (reset),
        .push_i      (q_push),
        .push_data_i (fill_packet_i),
        .pop_i       (q_pop),
        .pop_data_o  (cur_pkt),
        .empty_o     (q_empty),
        .full_o      (q_full)
    );

    assign last_flit = (idx == cur_pkt.len - 1'b1);
    assign q_pop     = inj_take_i && last_flit;  // tail accepted, packet gone

    // flit offered every run cycle while a packet is queued
    assign inj_valid_o = run_i && !q_empty;

    always_comb
    begin
        inj_flit_o.head = (idx == '0);
        inj_flit_o.tail = last_flit;
        inj_flit_o.src  = MY_ID;
        inj_flit_o.dst  = cur_pkt.dst;
        inj_flit_o.seq  = seq;
        inj_flit_o.idx  = idx;
    end

    // seq follows queue order, so numbering at the tail
    // gives the same numbers as numbering at fill time
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            idx <= '0;
            seq <= '0;
        end
        else if (q_pop)
        begin
            idx <= '0;
            seq <= seq + 1'b1;
        end
        else if (inj_take_i)
        begin
            idx <= idx + 1'b1;
        end
    end

    assign idle_o = q_empty && (idx == '0);

endmodule
